//--- logic/cpu_isa_pkg.sv
package cpu_isa_pkg;

   localparam int NB_REG        = 32;
   localparam int NB_REG_ADDR   = 5;
   localparam int REGFILE_DEPTH = 32;
   localparam int NB_IMEM_ADDR  = 8;
   localparam int NB_DMEM_ADDR  = 8;
   localparam int IMEM_DEPTH    = 1 << NB_IMEM_ADDR;
   localparam int DMEM_DEPTH    = 1 << NB_DMEM_ADDR;
   localparam int NB_INM        = 16;
   localparam int NB_J_INM      = 26;
   localparam int NB_OPCODE     = 6;
   localparam int NB_FUNCT      = 6;

   // Field positions in the instruction word
   localparam int MSB_OPCODE    = 31;
   localparam int MSB_RS        = 25;
   localparam int MSB_RT        = 20;
   localparam int MSB_RD        = 15;

   typedef enum logic [NB_OPCODE-1:0] {
      R_TYPE = 6'b000000,
      J      = 6'b000010,
      BEQ    = 6'b000100,
      BNE    = 6'b000101,
      ADDI   = 6'b001000,
      LW     = 6'b100011,
      SW     = 6'b101011,
      HALT   = 6'b111111
   } opcode_e;

   typedef enum logic [NB_FUNCT-1:0] {
      ADD = 6'b100000,
      SUB = 6'b100010,
      AND = 6'b100100,
      OR  = 6'b100101,
      SLT = 6'b101010
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

endpackage

//--- logic/cpu_pipe_pkg.sv
package cpu_pipe_pkg;

   import cpu_isa_pkg::*;

   // Decoded control, all zero is a bubble
   typedef struct packed {
      alu_op_e                alu_op;
      logic                   alu_src_imm;
      logic                   mem_read;
      logic                   mem_write;
      logic                   reg_write;
      logic [NB_REG_ADDR-1:0] dest;
      logic                   halt;
   } ctrl_t;

   typedef struct packed {
      logic [NB_REG-1:0] instr;
      logic [NB_REG-1:0] pc_plus4;
   } if_id_t;

   // Source indices ride along for operand forwarding in EX
   typedef struct packed {
      ctrl_t                  ctrl;
      logic [NB_REG_ADDR-1:0] rs;
      logic [NB_REG_ADDR-1:0] rt;
      logic [NB_REG-1:0]      a;
      logic [NB_REG-1:0]      b;
      logic [NB_REG-1:0]      imm;
   } id_ex_t;

   typedef struct packed {
      ctrl_t             ctrl;
      logic [NB_REG-1:0] alu_result;
      logic [NB_REG-1:0] store_data;
   } ex_mem_t;

   typedef struct packed {
      logic                   reg_write;
      logic [NB_REG_ADDR-1:0] dest;
      logic [NB_REG-1:0]      data;
   } wb_write_t;

endpackage

//--- logic/instruction_fetch.sv
module instruction_fetch
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  logic                    i_enable,
   input  logic                    i_stall,
   input  logic                    i_taken,
   input  logic [NB_REG-1:0]       i_target,
   input  logic                    i_imem_we,
   input  logic [NB_IMEM_ADDR-1:0] i_imem_addr,
   input  logic [NB_REG-1:0]       i_imem_data,
   output if_id_t                  o_if_id
);

   logic [NB_REG-1:0] imem [IMEM_DEPTH];
   logic [NB_REG-1:0] pc;
   logic [NB_REG-1:0] pc_plus4;
   logic [NB_REG-1:0] instr;
   logic              at_halt;

   assign instr    = imem[pc[NB_IMEM_ADDR+1:2]];
   assign pc_plus4 = pc + NB_REG'(4);
   assign at_halt  = (instr[MSB_OPCODE-:NB_OPCODE] == HALT);

   always_ff @(posedge i_clock) begin
      if (i_imem_we) begin
         imem[i_imem_addr] <= i_imem_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         pc      <= '0;
         o_if_id <= '0;
      end else if (i_enable && !i_stall) begin
         if (i_taken) begin
            // Redirect, the word fetched behind the branch is dropped
            pc      <= i_target;
            o_if_id <= '0;
         end else begin
            // PC parks on HALT
            if (!at_halt) begin
               pc <= pc_plus4;
            end
            o_if_id.instr    <= instr;
            o_if_id.pc_plus4 <= pc_plus4;
         end
      end
   end

   assert property (@(posedge i_clock) disable iff (i_reset) i_stall |=> $stable(pc))
      else $error("PC moved during a stall");

endmodule

//--- logic/instruction_decode.sv
module instruction_decode
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic                   i_clock,
   input  logic                   i_reset,
   input  if_id_t                 i_if_id,
   input  wb_write_t              i_wb,
   input  logic                   i_fwd_sel_a,
   input  logic                   i_fwd_sel_b,
   input  logic [NB_REG-1:0]      i_fwd_data_a,
   input  logic [NB_REG-1:0]      i_fwd_data_b,
   input  logic                   i_stall,
   input  logic [NB_REG_ADDR-1:0] i_dbg_reg_addr,
   output id_ex_t                 o_id_ex,
   output logic                   o_taken,
   output logic [NB_REG-1:0]      o_target,
   output logic [NB_REG-1:0]      o_dbg_reg_data
);

   logic [NB_REG-1:0]      regfile [REGFILE_DEPTH];
   opcode_e                opcode;
   funct_e                 funct;
   logic [NB_REG_ADDR-1:0] rs;
   logic [NB_REG_ADDR-1:0] rt;
   logic [NB_REG_ADDR-1:0] rd;
   logic [NB_REG-1:0]      imm_ext;
   logic [NB_REG-1:0]      read_a;
   logic [NB_REG-1:0]      read_b;
   logic [NB_REG-1:0]      cmp_a;
   logic [NB_REG-1:0]      cmp_b;
   logic                   equal;
   ctrl_t                  ctrl;

   assign opcode  = opcode_e'(i_if_id.instr[MSB_OPCODE-:NB_OPCODE]);
   assign funct   = funct_e'(i_if_id.instr[NB_FUNCT-1:0]);
   assign rs      = i_if_id.instr[MSB_RS-:NB_REG_ADDR];
   assign rt      = i_if_id.instr[MSB_RT-:NB_REG_ADDR];
   assign rd      = i_if_id.instr[MSB_RD-:NB_REG_ADDR];
   assign imm_ext = {{(NB_REG-NB_INM){i_if_id.instr[NB_INM-1]}}, i_if_id.instr[NB_INM-1:0]};

   // Write-first bypass stands in for the half-cycle write
   assign read_a = (i_wb.reg_write && i_wb.dest == rs && rs != '0) ? i_wb.data : regfile[rs];
   assign read_b = (i_wb.reg_write && i_wb.dest == rt && rt != '0) ? i_wb.data : regfile[rt];

   assign o_dbg_reg_data = regfile[i_dbg_reg_addr];

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         for (int i = 0; i < REGFILE_DEPTH; i++) begin
            regfile[i] <= '0;
         end
      end else if (i_wb.reg_write && i_wb.dest != '0) begin
         regfile[i_wb.dest] <= i_wb.data;
      end
   end

   always_comb begin
      ctrl = '0;
      case (opcode)
         R_TYPE: begin
            ctrl.dest      = rd;
            ctrl.reg_write = 1'b1;
            case (funct)
               ADD:     ctrl.alu_op = ALU_ADD;
               SUB:     ctrl.alu_op = ALU_SUB;
               AND:     ctrl.alu_op = ALU_AND;
               OR:      ctrl.alu_op = ALU_OR;
               SLT:     ctrl.alu_op = ALU_SLT;
               default: ctrl.reg_write = 1'b0;
            endcase
         end
         ADDI: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.dest        = rt;
         end
         LW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.reg_write   = 1'b1;
            ctrl.dest        = rt;
         end
         SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.mem_write   = 1'b1;
         end
         HALT:    ctrl.halt = 1'b1;
         default: ctrl = '0;
      endcase
   end

   // Branch compare on forwarded operands
   assign cmp_a = i_fwd_sel_a ? i_fwd_data_a : read_a;
   assign cmp_b = i_fwd_sel_b ? i_fwd_data_b : read_b;
   assign equal = (cmp_a == cmp_b);

   assign o_taken = !i_stall && ((opcode == J) || (opcode == BEQ && equal) ||
                                 (opcode == BNE && !equal));
   assign o_target = (opcode == J) ?
      {i_if_id.pc_plus4[NB_REG-1:NB_J_INM+2], i_if_id.instr[NB_J_INM-1:0], 2'b00} :
      i_if_id.pc_plus4 + {imm_ext[NB_REG-3:0], 2'b00};

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_id_ex.ctrl <= '0;
      end else begin
         o_id_ex.ctrl <= i_stall ? '0 : ctrl;
         o_id_ex.rs   <= rs;
         o_id_ex.rt   <= rt;
         o_id_ex.a    <= read_a;
         o_id_ex.b    <= read_b;
         o_id_ex.imm  <= imm_ext;
      end
   end

   assert property (@(posedge i_clock) disable iff (i_reset) regfile[0] == '0)
      else $error("Register 0 holds a nonzero value");

endmodule

//--- logic/execution.sv
module execution
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic              i_clock,
   input  logic              i_reset,
   input  id_ex_t            i_id_ex,
   input  logic              i_fwd_sel_a,
   input  logic              i_fwd_sel_b,
   input  logic [NB_REG-1:0] i_fwd_data_a,
   input  logic [NB_REG-1:0] i_fwd_data_b,
   output ex_mem_t           o_ex_mem
);

   logic [NB_REG-1:0] op_a;
   logic [NB_REG-1:0] reg_b;
   logic [NB_REG-1:0] op_b;
   logic [NB_REG-1:0] result;

   assign op_a  = i_fwd_sel_a ? i_fwd_data_a : i_id_ex.a;
   assign reg_b = i_fwd_sel_b ? i_fwd_data_b : i_id_ex.b;
   assign op_b  = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : reg_b;

   always_comb begin
      case (i_id_ex.ctrl.alu_op)
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_SLT: result = {{(NB_REG-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         default: result = op_a + op_b;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         o_ex_mem.ctrl <= '0;
      end else begin
         o_ex_mem.ctrl       <= i_id_ex.ctrl;
         o_ex_mem.alu_result <= result;
         // Store data takes the forwarded B, not the immediate
         o_ex_mem.store_data <= reg_b;
      end
   end

endmodule

//--- logic/memory_access.sv
module memory_access
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic      i_clock,
   input  logic      i_reset,
   input  ex_mem_t   i_ex_mem,
   output wb_write_t o_wb,
   output logic      o_halt_wb
);

   logic [NB_REG-1:0]       dmem [DMEM_DEPTH];
   logic [NB_DMEM_ADDR-1:0] addr;
   logic                    wb_reg_write;
   logic                    wb_mem_read;
   logic [NB_REG_ADDR-1:0]  wb_dest;
   logic [NB_REG-1:0]       wb_alu;
   logic [NB_REG-1:0]       wb_load;

   // Word address from the byte address
   assign addr = i_ex_mem.alu_result[NB_DMEM_ADDR+1:2];

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i] <= '0;
         end
      end else if (i_ex_mem.ctrl.mem_write) begin
         dmem[addr] <= i_ex_mem.store_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         wb_reg_write <= 1'b0;
         wb_mem_read  <= 1'b0;
         o_halt_wb    <= 1'b0;
      end else begin
         wb_reg_write <= i_ex_mem.ctrl.reg_write;
         wb_mem_read  <= i_ex_mem.ctrl.mem_read;
         o_halt_wb    <= i_ex_mem.ctrl.halt;
         wb_dest      <= i_ex_mem.ctrl.dest;
         wb_alu       <= i_ex_mem.alu_result;
         wb_load      <= dmem[addr];
      end
   end

   // Write-back select
   assign o_wb.reg_write = wb_reg_write;
   assign o_wb.dest      = wb_dest;
   assign o_wb.data      = wb_mem_read ? wb_load : wb_alu;

   assert property (@(posedge i_clock) disable iff (i_reset)
                    !(i_ex_mem.ctrl.mem_read && i_ex_mem.ctrl.mem_write))
      else $error("Load and store issued together");

endmodule

//--- logic/shortcircuit_unit.sv
module shortcircuit_unit
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  ex_mem_t           i_ex_mem,
   input  wb_write_t         i_wb,
   input  id_ex_t            i_id_ex,
   input  if_id_t            i_if_id,
   output logic              o_dec_sel_a,
   output logic              o_dec_sel_b,
   output logic [NB_REG-1:0] o_dec_data_a,
   output logic [NB_REG-1:0] o_dec_data_b,
   output logic              o_ex_sel_a,
   output logic              o_ex_sel_b,
   output logic [NB_REG-1:0] o_ex_data_a,
   output logic [NB_REG-1:0] o_ex_data_b
);

   // Select bit on top, forwarded value below; EX/MEM is newer than write-back
   function automatic logic [NB_REG:0] pick(input logic [NB_REG_ADDR-1:0] src);
      logic mem_hit;
      logic wb_hit;
      mem_hit = i_ex_mem.ctrl.reg_write && i_ex_mem.ctrl.dest == src && src != '0;
      wb_hit  = i_wb.reg_write && i_wb.dest == src && src != '0;
      if (mem_hit) begin
         return {1'b1, i_ex_mem.alu_result};
      end
      return {wb_hit, i_wb.data};
   endfunction

   always_comb begin
      {o_dec_sel_a, o_dec_data_a} = pick(i_if_id.instr[MSB_RS-:NB_REG_ADDR]);
      {o_dec_sel_b, o_dec_data_b} = pick(i_if_id.instr[MSB_RT-:NB_REG_ADDR]);
      {o_ex_sel_a, o_ex_data_a}   = pick(i_id_ex.rs);
      {o_ex_sel_b, o_ex_data_b}   = pick(i_id_ex.rt);
   end

endmodule

//--- logic/hazard_unit.sv
module hazard_unit
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  id_ex_t  i_id_ex,
   input  ex_mem_t i_ex_mem,
   input  if_id_t  i_if_id,
   output logic    o_stall
);

   opcode_e                opcode;
   logic [NB_REG_ADDR-1:0] rs;
   logic [NB_REG_ADDR-1:0] rt;
   logic                   reads_rs;
   logic                   reads_rt;
   logic                   is_branch;
   logic                   ex_hit;
   logic                   mem_hit;

   assign opcode    = opcode_e'(i_if_id.instr[MSB_OPCODE-:NB_OPCODE]);
   assign rs        = i_if_id.instr[MSB_RS-:NB_REG_ADDR];
   assign rt        = i_if_id.instr[MSB_RT-:NB_REG_ADDR];
   assign reads_rs  = opcode inside {R_TYPE, ADDI, LW, SW, BEQ, BNE};
   assign reads_rt  = opcode inside {R_TYPE, SW, BEQ, BNE};
   assign is_branch = opcode inside {BEQ, BNE};

   assign ex_hit = i_id_ex.ctrl.reg_write && i_id_ex.ctrl.dest != '0 &&
                   ((reads_rs && rs == i_id_ex.ctrl.dest) ||
                    (reads_rt && rt == i_id_ex.ctrl.dest));
   assign mem_hit = i_ex_mem.ctrl.reg_write && i_ex_mem.ctrl.dest != '0 &&
                    ((reads_rs && rs == i_ex_mem.ctrl.dest) ||
                     (reads_rt && rt == i_ex_mem.ctrl.dest));

   // A branch behind a load waits until the load data sits in write-back
   assign o_stall = (ex_hit && (i_id_ex.ctrl.mem_read || is_branch)) ||
                    (mem_hit && is_branch && i_ex_mem.ctrl.mem_read);

   assert final (!o_stall || i_id_ex.ctrl != '0 || i_ex_mem.ctrl != '0)
      else $error("Stall with nothing in flight");

endmodule

//--- logic/pipeline.sv
module pipeline
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic                    i_clock,
   input  logic                    i_reset,
   input  logic                    i_run,
   input  logic                    i_imem_we,
   input  logic [NB_IMEM_ADDR-1:0] i_imem_addr,
   input  logic [NB_REG-1:0]       i_imem_data,
   input  logic [NB_REG_ADDR-1:0]  i_dbg_reg_addr,
   output logic [NB_REG-1:0]       o_dbg_reg_data,
   output logic                    o_halt
);

   if_id_t            if_id;
   id_ex_t            id_ex;
   ex_mem_t           ex_mem;
   wb_write_t         wb;
   logic              taken;
   logic [NB_REG-1:0] target;
   logic              hazard_stall;
   logic              run_en;
   logic              dec_stall;
   logic              halt_wb;
   logic              halt_q;
   logic              dec_sel_a;
   logic              dec_sel_b;
   logic [NB_REG-1:0] dec_data_a;
   logic [NB_REG-1:0] dec_data_b;
   logic              ex_sel_a;
   logic              ex_sel_b;
   logic [NB_REG-1:0] ex_data_a;
   logic [NB_REG-1:0] ex_data_b;

   // Fetch frozen, decode feeds bubbles so the held IF/ID is not issued twice
   assign run_en    = i_run && !halt_q;
   assign dec_stall = hazard_stall || !run_en;
   assign o_halt    = halt_q;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         halt_q <= 1'b0;
      end else if (halt_wb) begin
         halt_q <= 1'b1;
      end
   end

   instruction_fetch u_instruction_fetch (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_enable    (run_en),
      .i_stall     (hazard_stall),
      .i_taken     (taken),
      .i_target    (target),
      .i_imem_we   (i_imem_we),
      .i_imem_addr (i_imem_addr),
      .i_imem_data (i_imem_data),
      .o_if_id     (if_id)
   );

   instruction_decode u_instruction_decode (
      .i_clock        (i_clock),
      .i_reset        (i_reset),
      .i_if_id        (if_id),
      .i_wb           (wb),
      .i_fwd_sel_a    (dec_sel_a),
      .i_fwd_sel_b    (dec_sel_b),
      .i_fwd_data_a   (dec_data_a),
      .i_fwd_data_b   (dec_data_b),
      .i_stall        (dec_stall),
      .i_dbg_reg_addr (i_dbg_reg_addr),
      .o_id_ex        (id_ex),
      .o_taken        (taken),
      .o_target       (target),
      .o_dbg_reg_data (o_dbg_reg_data)
   );

   execution u_execution (
      .i_clock      (i_clock),
      .i_reset      (i_reset),
      .i_id_ex      (id_ex),
      .i_fwd_sel_a  (ex_sel_a),
      .i_fwd_sel_b  (ex_sel_b),
      .i_fwd_data_a (ex_data_a),
      .i_fwd_data_b (ex_data_b),
      .o_ex_mem     (ex_mem)
   );

   memory_access u_memory_access (
      .i_clock   (i_clock),
      .i_reset   (i_reset),
      .i_ex_mem  (ex_mem),
      .o_wb      (wb),
      .o_halt_wb (halt_wb)
   );

   shortcircuit_unit u_shortcircuit_unit (
      .i_ex_mem     (ex_mem),
      .i_wb         (wb),
      .i_id_ex      (id_ex),
      .i_if_id      (if_id),
      .o_dec_sel_a  (dec_sel_a),
      .o_dec_sel_b  (dec_sel_b),
      .o_dec_data_a (dec_data_a),
      .o_dec_data_b (dec_data_b),
      .o_ex_sel_a   (ex_sel_a),
      .o_ex_sel_b   (ex_sel_b),
      .o_ex_data_a  (ex_data_a),
      .o_ex_data_b  (ex_data_b)
   );

   hazard_unit u_hazard_unit (
      .i_id_ex  (id_ex),
      .i_ex_mem (ex_mem),
      .i_if_id  (if_id),
      .o_stall  (hazard_stall)
   );

   assert property (@(posedge i_clock) disable iff (i_reset) o_halt |=> o_halt)
      else $error("Halt dropped without reset");

endmodule

//--- tb/pipeline_tb.sv
module pipeline_tb
   import cpu_isa_pkg::*;
();

   localparam int RESET_CYCLES = 10;
   localparam int DRIVE_DELAY  = 10;
   localparam int NUM_RANDOM   = 20;
   localparam int RANDOM_LEN   = 40;

   logic                    i_clock;
   logic                    i_reset;
   logic                    i_run;
   logic                    i_imem_we;
   logic [NB_IMEM_ADDR-1:0] i_imem_addr;
   logic [NB_REG-1:0]       i_imem_data;
   logic [NB_REG_ADDR-1:0]  i_dbg_reg_addr;
   logic [NB_REG-1:0]       o_dbg_reg_data;
   logic                    o_halt;

   logic [31:0] prog [256];
   int          prog_len;
   logic [31:0] model_regs [32];
   logic [31:0] model_mem [256];
   int          seed;
   int          checks;
   int          errors;
   int          timeouts;
   int          run_cycles;
   int          run_limit;
   string       test_name;

   pipeline u_pipeline (
      .i_clock        (i_clock),
      .i_reset        (i_reset),
      .i_run          (i_run),
      .i_imem_we      (i_imem_we),
      .i_imem_addr    (i_imem_addr),
      .i_imem_data    (i_imem_data),
      .i_dbg_reg_addr (i_dbg_reg_addr),
      .o_dbg_reg_data (o_dbg_reg_data),
      .o_halt         (o_halt)
   );

   initial begin
      i_clock = 1'b0;
      forever #50 i_clock = ~i_clock;
   end

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [31:0] r_word(input funct_e f, input int rd, input int rs,
                                          input int rt);
      return {R_TYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
   endfunction

   function automatic logic [31:0] i_word(input opcode_e op, input int rt, input int rs,
                                          input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   function automatic logic [31:0] j_word(input int target);
      return {J, 26'(target)};
   endfunction

   task automatic emit(input logic [31:0] word);
      prog[prog_len] = word;
      prog_len++;
   endtask

   task automatic report_and_finish();
      $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   endtask

   // Instruction-set model, one instruction per step, no delay slot
   task automatic run_model();
      int          pc;
      int          next;
      int          steps;
      bit          done;
      bit          wr_en;
      logic [4:0]  dst;
      logic [31:0] ins;
      logic [31:0] va;
      logic [31:0] vb;
      logic [31:0] imm;
      logic [31:0] ea;
      logic [31:0] val;
      for (int r = 0; r < 32; r++) begin
         model_regs[r] = '0;
      end
      for (int w = 0; w < 256; w++) begin
         model_mem[w] = '0;
      end
      pc    = 0;
      steps = 0;
      done  = 1'b0;
      while (!done && steps < 4096) begin
         ins   = prog[pc];
         va    = model_regs[ins[25:21]];
         vb    = model_regs[ins[20:16]];
         imm   = {{16{ins[15]}}, ins[15:0]};
         ea    = va + imm;
         next  = pc + 1;
         wr_en = 1'b0;
         dst   = ins[20:16];
         val   = '0;
         case (opcode_e'(ins[31:26]))
            R_TYPE: begin
               wr_en = 1'b1;
               dst   = ins[15:11];
               case (funct_e'(ins[5:0]))
                  ADD:     val = va + vb;
                  SUB:     val = va - vb;
                  AND:     val = va & vb;
                  OR:      val = va | vb;
                  SLT:     val = ($signed(va) < $signed(vb)) ? 32'd1 : 32'd0;
                  default: wr_en = 1'b0;
               endcase
            end
            ADDI: begin
               wr_en = 1'b1;
               val   = va + imm;
            end
            LW: begin
               wr_en = 1'b1;
               val   = model_mem[ea[9:2]];
            end
            SW:      model_mem[ea[9:2]] = vb;
            BEQ:     if (va == vb) next = pc + 1 + int'($signed(imm));
            BNE:     if (va != vb) next = pc + 1 + int'($signed(imm));
            J:       next = int'(ins[25:0]);
            HALT:    done = 1'b1;
            default: ;
         endcase
         if (wr_en && dst != 5'd0) begin
            model_regs[dst] = val;
         end
         pc = next;
         steps++;
      end
   endtask

   task automatic check_reg(input int r, input logic [31:0] expected);
      @(posedge i_clock);
      #DRIVE_DELAY;
      i_dbg_reg_addr = 5'(r);
      #DRIVE_DELAY;
      checks++;
      assert (o_dbg_reg_data === expected)
         else begin
            errors++;
            $display("[ERROR] %0t %s: o_dbg_reg_data for r%0d is %h, expected %h",
                     $time, test_name, r, o_dbg_reg_data, expected);
         end
   endtask

   task automatic run_program(input string name);
      test_name = name;
      run_model();
      run_limit += 4 * prog_len + 20;
      @(posedge i_clock);
      #DRIVE_DELAY;
      i_reset = 1'b1;
      i_run   = 1'b0;
      repeat (RESET_CYCLES) @(posedge i_clock);
      #DRIVE_DELAY;
      i_reset = 1'b0;
      for (int a = 0; a < prog_len; a++) begin
         i_imem_we   = 1'b1;
         i_imem_addr = NB_IMEM_ADDR'(a);
         i_imem_data = prog[a];
         @(posedge i_clock);
         #DRIVE_DELAY;
      end
      i_imem_we = 1'b0;
      // Reset state
      checks++;
      assert (o_halt === 1'b0)
         else begin
            errors++;
            $display("[ERROR] %0t %s: o_halt is %b, expected 0", $time, test_name, o_halt);
         end
      for (int r = 0; r < 32; r++) begin
         check_reg(r, '0);
      end
      i_run = 1'b1;
      while (o_halt !== 1'b1) begin
         @(posedge i_clock);
         #DRIVE_DELAY;
      end
      i_run = 1'b0;
      for (int r = 0; r < 32; r++) begin
         check_reg(r, model_regs[r]);
      end
   endtask

   // Both forwarding stages, every ALU operation
   task automatic build_alu_chain();
      prog_len = 0;
      emit(i_word(ADDI, 1, 0, 5));
      emit(i_word(ADDI, 2, 0, -3));
      emit(r_word(ADD, 3, 1, 2));
      emit(r_word(SUB, 4, 3, 1));
      emit(r_word(AND, 5, 4, 3));
      emit(r_word(OR, 6, 5, 2));
      emit(r_word(SLT, 7, 2, 1));
      emit(r_word(SLT, 8, 1, 2));
      emit(i_word(ADDI, 9, 7, 100));
      emit(r_word(ADD, 10, 9, 9));
      emit({HALT, 26'd0});
   endtask

   task automatic build_load_store();
      prog_len = 0;
      emit(i_word(ADDI, 1, 0, 16'h1234));
      emit(i_word(ADDI, 2, 0, 8));
      emit(i_word(SW, 1, 2, 4));
      emit(i_word(LW, 3, 2, 4));
      emit(r_word(ADD, 4, 3, 3));
      emit(i_word(LW, 5, 0, 12));
      emit(i_word(SW, 4, 2, -4));
      emit(i_word(LW, 6, 0, 4));
      // Branch right behind a load
      emit(i_word(BEQ, 4, 6, 1));
      emit(i_word(ADDI, 7, 0, 1));
      emit(i_word(ADDI, 8, 0, 2));
      emit({HALT, 26'd0});
   endtask

   task automatic build_branches();
      prog_len = 0;
      emit(i_word(ADDI, 1, 0, 7));
      emit(i_word(ADDI, 2, 0, 7));
      emit(i_word(BEQ, 2, 1, 1));
      emit(i_word(ADDI, 3, 0, 99));
      emit(i_word(BNE, 2, 1, 1));
      emit(i_word(ADDI, 4, 0, 11));
      emit(r_word(SUB, 5, 1, 2));
      emit(i_word(BNE, 0, 5, 1));
      emit(i_word(ADDI, 6, 0, 12));
      emit(i_word(BEQ, 0, 5, 2));
      emit(i_word(ADDI, 7, 0, 13));
      emit(i_word(ADDI, 8, 0, 14));
      emit(j_word(prog_len + 2));
      emit(i_word(ADDI, 9, 0, 15));
      emit(i_word(ADDI, 10, 4, 1));
      emit({HALT, 26'd0});
   endtask

   task automatic build_zero_reg();
      prog_len = 0;
      emit(i_word(ADDI, 0, 0, 55));
      emit(r_word(ADD, 1, 0, 0));
      emit(i_word(ADDI, 0, 0, -1));
      emit(i_word(ADDI, 2, 0, 3));
      emit(i_word(LW, 0, 0, 0));
      emit(r_word(SUB, 0, 2, 1));
      emit(r_word(OR, 3, 0, 2));
      emit(i_word(BNE, 0, 0, 1));
      emit(i_word(ADDI, 4, 0, 9));
      emit({HALT, 26'd0});
   endtask

   // Forward branches only, registers r0 to r7 so hazards are frequent
   task automatic build_random(input int len);
      int rd;
      int rs;
      int rt;
      int span;
      prog_len = 0;
      for (int k = 0; k < len - 1; k++) begin
         rd   = rand_below(8);
         rs   = rand_below(8);
         rt   = rand_below(8);
         span = len - 2 - k;
         case (rand_below(13))
            0:       emit(r_word(ADD, rd, rs, rt));
            1:       emit(r_word(SUB, rd, rs, rt));
            2:       emit(r_word(AND, rd, rs, rt));
            3:       emit(r_word(OR, rd, rs, rt));
            4:       emit(r_word(SLT, rd, rs, rt));
            5, 6:    emit(i_word(ADDI, rd, rs, rand_below(16) - 8));
            7:       emit(i_word(LW, rd, rs, 4 * rand_below(8)));
            8:       emit(i_word(SW, rt, rs, 4 * rand_below(8)));
            9:       emit(i_word(BEQ, rt, rs, rand_below(span + 1)));
            10:      emit(i_word(BNE, rt, rs, rand_below(span + 1)));
            11:      emit(j_word(k + 1 + rand_below(span + 1)));
            default: emit(i_word(ADDI, rd, 0, rand_below(4)));
         endcase
      end
      emit({HALT, 26'd0});
   endtask

   always @(posedge i_clock) begin
      if (i_run) begin
         run_cycles++;
         if (run_cycles > run_limit) begin
            $display("Timeout in %s: o_halt did not rise within %0d run cycles",
                     test_name, run_limit);
            timeouts++;
            report_and_finish();
         end
      end
   end

   initial begin
      seed           = 17503;
      checks         = 0;
      errors         = 0;
      timeouts       = 0;
      run_cycles     = 0;
      run_limit      = 0;
      i_reset        = 1'b1;
      i_run          = 1'b0;
      i_imem_we      = 1'b0;
      i_imem_addr    = '0;
      i_imem_data    = '0;
      i_dbg_reg_addr = '0;
      build_alu_chain();
      run_program("alu chain");
      build_load_store();
      run_program("load store");
      build_branches();
      run_program("branches");
      build_zero_reg();
      run_program("register zero");
      for (int p = 0; p < NUM_RANDOM; p++) begin
         build_random(RANDOM_LEN);
         run_program($sformatf("random program %0d", p));
      end
      report_and_finish();
   end

endmodule

//--- sim.f
logic/cpu_isa_pkg.sv
logic/cpu_pipe_pkg.sv
logic/instruction_fetch.sv
logic/instruction_decode.sv
logic/execution.sv
logic/memory_access.sv
logic/shortcircuit_unit.sv
logic/hazard_unit.sv
logic/pipeline.sv
tb/pipeline_tb.sv
